// ==== verilog/cce_cfg_pkg.sv ====
package cce_cfg_pkg;

  localparam int inst_width_c          = 24;
  localparam int cfg_data_width_c      = 16;
  localparam int cfg_addr_width_c      = 7;
  localparam int inst_ram_els_c        = 16;
  localparam int inst_ram_addr_width_c = 4;

  // bit 6 picks register space, bits 4 to 1 index the RAM, bit 0 picks the high half
  localparam logic [cfg_addr_width_c-1:0] cfg_mode_addr_c = 7'h40;

  typedef enum logic [1:0] {
    e_mode_uncached = 2'd0,
    e_mode_normal   = 2'd1,
    e_mode_invalid  = 2'd2
  } cce_mode_e;

  typedef enum logic [2:0] {
    op_nop  = 3'd0,
    op_addi = 3'd1,
    op_xori = 3'd2,
    op_shl  = 3'd3,
    op_emit = 3'd4,
    op_halt = 3'd5
  } ucode_op_e;

  typedef struct packed {
    logic [cfg_addr_width_c-1:0] addr;
    logic [cfg_data_width_c-1:0] data;
  } cfg_req_s;

  typedef struct packed {
    ucode_op_e   op;
    logic [4:0]  spare;
    logic [15:0] imm;
  } ucode_inst_s;

  typedef struct packed {
    logic [inst_ram_addr_width_c-1:0] pc;
    logic [15:0]                      value;
  } ucode_result_s;

endpackage

// ==== verilog/cce_cfg_loader.sv ====
module cce_cfg_loader
  #(parameter inst_ram_els_p = cce_cfg_pkg::inst_ram_els_c
    , localparam addr_width_lp = $clog2(inst_ram_els_p)
  )
  (input                                          clk_i
   , input                                        reset_i
   , output logic                                 freeze_o

   , output logic [addr_width_lp-1:0]             boot_rom_addr_o
   , input [cce_cfg_pkg::inst_width_c-1:0]        boot_rom_data_i

   , output cce_cfg_pkg::cfg_req_s                cfg_req_o
   , output logic                                 cfg_v_o
   , input                                        cfg_ready_i
  );

  import cce_cfg_pkg::*;

  localparam int cfg_writes_lp    = 2*inst_ram_els_p;
  localparam int data_hi_width_lp = inst_width_c - cfg_data_width_c;
  localparam int data_hi_pad_lp   = cfg_data_width_c - data_hi_width_lp;
  localparam int mode_pad_lp      = cfg_data_width_c - $bits(cce_mode_e);

  typedef enum logic [2:0] {
    e_reset,
    e_pause,
    e_send_ram,
    e_send_mode,
    e_done
  } load_state_e;

  load_state_e state_r, state_n;

  logic [cfg_addr_width_c-1:0] cfg_addr_r, cfg_addr_n;
  logic                        freeze_r, freeze_n;
  logic                        cfg_hi;
  logic                        last_write;

  assign freeze_o        = freeze_r;
  assign cfg_hi          = cfg_addr_r[0]; // odd link addresses carry the upper instruction bits
  assign boot_rom_addr_o = cfg_addr_r[1 +: addr_width_lp];

  // the final high half is the write just before the mode register
  assign last_write = (cfg_addr_r[0 +: addr_width_lp+1]
                       == (addr_width_lp+1)'(cfg_writes_lp-1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r    <= e_reset;
      cfg_addr_r <= '0;
      freeze_r   <= 1'b1; // engine stays frozen until the mode write lands
    end else begin
      state_r    <= state_n;
      cfg_addr_r <= cfg_addr_n;
      freeze_r   <= freeze_n;
    end
  end

  always_comb begin
    state_n    = state_r;
    cfg_addr_n = cfg_addr_r;
    freeze_n   = freeze_r;
    cfg_v_o    = 1'b0;
    cfg_req_o  = '0;

    case (state_r)
      e_reset: begin
        state_n = e_pause;
      end
      e_pause: begin
        state_n = e_send_ram;
      end
      e_send_ram: begin
        cfg_v_o        = 1'b1;
        cfg_req_o.addr = cfg_addr_r;
        cfg_req_o.data = cfg_hi
          ? {{data_hi_pad_lp{1'b0}}, boot_rom_data_i[cfg_data_width_c +: data_hi_width_lp]}
          : boot_rom_data_i[0 +: cfg_data_width_c];
        if (cfg_ready_i) begin
          if (last_write) begin
            cfg_addr_n = cfg_mode_addr_c; // jump to register space
            state_n    = e_send_mode;
          end else begin
            cfg_addr_n = cfg_addr_r + 1'b1;
          end
        end
      end
      e_send_mode: begin
        cfg_v_o        = 1'b1;
        cfg_req_o.addr = cfg_addr_r;
        cfg_req_o.data = {{mode_pad_lp{1'b0}}, e_mode_normal};
        if (cfg_ready_i) begin
          freeze_n = 1'b0; // mode becomes normal on the same edge
          state_n  = e_done;
        end
      end
      e_done: begin
        state_n = e_done;
      end
      default: begin
        state_n = e_reset;
      end
    endcase
  end

endmodule

// ==== verilog/cce_cfg_decode.sv ====
module cce_cfg_decode
  (input                                                 clk_i
   , input                                               reset_i

   , input cce_cfg_pkg::cfg_req_s                        cfg_req_i
   , input                                               cfg_v_i
   , output logic                                        cfg_ready_o

   , output logic                                        ram_w_v_o
   , output logic                                        ram_hi_o
   , output logic [cce_cfg_pkg::cfg_addr_width_c-3:0]    ram_index_o
   , output logic [cce_cfg_pkg::cfg_data_width_c-1:0]    ram_data_o

   , output cce_cfg_pkg::cce_mode_e                      mode_o
  );

  import cce_cfg_pkg::*;

  localparam int mode_width_lp = $bits(cce_mode_e);

  logic      xfer;
  logic      reg_space;
  logic      mode_we;
  logic      busy_r;
  cce_mode_e mode_r;

  // the RAM needs one idle cycle to commit a full instruction
  assign cfg_ready_o = ~busy_r;
  assign xfer        = cfg_v_i & cfg_ready_o;

  assign reg_space = cfg_req_i.addr[cfg_addr_width_c-1];

  // RAM space fields pass straight through, the strobe qualifies them
  assign ram_w_v_o   = xfer & ~reg_space;
  assign ram_hi_o    = cfg_req_i.addr[0];
  assign ram_index_o = cfg_req_i.addr[1 +: cfg_addr_width_c-2];
  assign ram_data_o  = cfg_req_i.data;

  // other register addresses are accepted and dropped
  assign mode_we = xfer & (cfg_req_i.addr == cfg_mode_addr_c);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r <= 1'b0;
      mode_r <= e_mode_uncached;
    end else begin
      busy_r <= ram_w_v_o & ram_hi_o; // holds for one cycle only since ready is low meanwhile
      if (mode_we) begin
        mode_r <= cce_mode_e'(cfg_req_i.data[mode_width_lp-1:0]);
      end
    end
  end

  assign mode_o = mode_r;

endmodule

// ==== verilog/cce_inst_ram.sv ====
module cce_inst_ram
  #(parameter inst_ram_els_p = cce_cfg_pkg::inst_ram_els_c
    , localparam addr_width_lp = $clog2(inst_ram_els_p)
  )
  (input                                              clk_i
   , input                                            reset_i

   , input                                            w_v_i
   , input                                            w_hi_i
   , input [cce_cfg_pkg::cfg_addr_width_c-3:0]        w_index_i
   , input [cce_cfg_pkg::cfg_data_width_c-1:0]        w_data_i

   , input [addr_width_lp-1:0]                        rd_addr_i
   , output cce_cfg_pkg::ucode_inst_s                 rd_data_o
  );

  import cce_cfg_pkg::*;

  localparam int data_hi_width_lp = inst_width_c - cfg_data_width_c;

  ucode_inst_s                 mem [inst_ram_els_p];
  logic [cfg_data_width_c-1:0] stage_r;
  ucode_inst_s                 rd_data_r;
  logic [addr_width_lp-1:0]    w_addr;

  assign w_addr = w_index_i[0 +: addr_width_lp];

  // low half waits here until its high half arrives
  always_ff @(posedge clk_i) begin
    if (w_v_i & ~w_hi_i) begin
      stage_r <= w_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_v_i & w_hi_i) begin
      mem[w_addr] <= ucode_inst_s'({w_data_i[0 +: data_hi_width_lp], stage_r});
    end
  end

  // read port comes up as a nop until the first real read
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_data_r <= '{op: op_nop, spare: '0, imm: '0};
    end else begin
      rd_data_r <= mem[rd_addr_i];
    end
  end

  assign rd_data_o = rd_data_r;

endmodule

// ==== verilog/cce_ucode_exec.sv ====
module cce_ucode_exec
  #(parameter inst_ram_els_p = cce_cfg_pkg::inst_ram_els_c
    , localparam addr_width_lp = $clog2(inst_ram_els_p)
  )
  (input                                    clk_i
   , input                                  reset_i

   , input                                  freeze_i
   , input cce_cfg_pkg::cce_mode_e          mode_i

   , output logic [addr_width_lp-1:0]       rd_addr_o
   , input cce_cfg_pkg::ucode_inst_s        rd_data_i

   , output logic                           result_v_o
   , output cce_cfg_pkg::ucode_result_s     result_o
   , output logic                           done_o
  );

  import cce_cfg_pkg::*;

  localparam logic [addr_width_lp-1:0] last_pc_lp = addr_width_lp'(inst_ram_els_p-1);

  logic [addr_width_lp-1:0] fetch_pc_r;
  logic [addr_width_lp-1:0] exec_pc_r;
  logic                     exec_v_r;
  logic [15:0]              acc_r, acc_n;
  logic                     done_r;
  logic                     run;
  logic                     exec_stop;

  assign run       = ~freeze_i & (mode_i == e_mode_normal) & ~done_r;
  assign rd_addr_o = fetch_pc_r;

  // halt and the last slot both end the program
  assign exec_stop = exec_v_r & ((rd_data_i.op == op_halt) | (exec_pc_r == last_pc_lp));

  always_comb begin
    acc_n = acc_r;
    case (rd_data_i.op)
      op_addi: acc_n = acc_r + rd_data_i.imm;
      op_xori: acc_n = acc_r ^ rd_data_i.imm;
      op_shl:  acc_n = acc_r << rd_data_i.imm[3:0];
      default: acc_n = acc_r; // nop, emit, halt and unused encodings leave it alone
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fetch_pc_r <= '0;
      exec_pc_r  <= '0;
      exec_v_r   <= 1'b0;
      done_r     <= 1'b0;
    end else if (exec_stop) begin
      done_r   <= 1'b1;
      exec_v_r <= 1'b0; // drops the fetch already issued behind it
    end else if (run) begin
      exec_v_r   <= 1'b1;
      exec_pc_r  <= fetch_pc_r;
      fetch_pc_r <= fetch_pc_r + 1'b1;
    end else begin
      exec_v_r <= 1'b0; // fetch_pc_r still points at the dropped read, so it is redone later
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      acc_r <= '0;
    end else if (exec_v_r) begin
      acc_r <= acc_n;
    end
  end

  assign result_v_o     = exec_v_r & (rd_data_i.op == op_emit);
  assign result_o.pc    = inst_ram_addr_width_c'(exec_pc_r);
  assign result_o.value = acc_r;
  assign done_o         = done_r;

endmodule

// ==== verilog/cce_boot_top.sv ====
module cce_boot_top
  #(parameter inst_ram_els_p = cce_cfg_pkg::inst_ram_els_c
    , localparam addr_width_lp = $clog2(inst_ram_els_p)
  )
  (input                                        clk_i
   , input                                      reset_i

   , output logic [addr_width_lp-1:0]           boot_rom_addr_o
   , input [cce_cfg_pkg::inst_width_c-1:0]      boot_rom_data_i

   , output logic                               freeze_o
   , output logic                               result_v_o
   , output cce_cfg_pkg::ucode_result_s         result_o
   , output logic                               done_o
  );

  import cce_cfg_pkg::*;

  cfg_req_s                    cfg_req;
  logic                        cfg_v;
  logic                        cfg_ready;
  logic                        ram_w_v;
  logic                        ram_hi;
  logic [cfg_addr_width_c-3:0] ram_index;
  logic [cfg_data_width_c-1:0] ram_data;
  cce_mode_e                   mode;
  logic                        freeze;
  logic [addr_width_lp-1:0]    rd_addr;
  ucode_inst_s                 rd_data;

  assign freeze_o = freeze;

  cce_cfg_loader #(.inst_ram_els_p(inst_ram_els_p)) loader
    (.clk_i, .reset_i, .freeze_o(freeze), .boot_rom_addr_o, .boot_rom_data_i
     , .cfg_req_o(cfg_req), .cfg_v_o(cfg_v), .cfg_ready_i(cfg_ready));

  cce_cfg_decode decode
    (.clk_i, .reset_i, .cfg_req_i(cfg_req), .cfg_v_i(cfg_v), .cfg_ready_o(cfg_ready)
     , .ram_w_v_o(ram_w_v), .ram_hi_o(ram_hi), .ram_index_o(ram_index)
     , .ram_data_o(ram_data), .mode_o(mode));

  cce_inst_ram #(.inst_ram_els_p(inst_ram_els_p)) inst_ram
    (.clk_i, .reset_i, .w_v_i(ram_w_v), .w_hi_i(ram_hi), .w_index_i(ram_index)
     , .w_data_i(ram_data), .rd_addr_i(rd_addr), .rd_data_o(rd_data));

  cce_ucode_exec #(.inst_ram_els_p(inst_ram_els_p)) exec
    (.clk_i, .reset_i, .freeze_i(freeze), .mode_i(mode), .rd_addr_o(rd_addr)
     , .rd_data_i(rd_data), .result_v_o, .result_o, .done_o);

endmodule

// ==== sim/cce_boot_assertions.sv ====
module cce_boot_assertions
  (input                                  clk_i
   , input                                reset_i
   , input cce_cfg_pkg::cfg_req_s         cfg_req_i
   , input                                cfg_v_i
   , input                                cfg_ready_i
   , input                                ram_w_v_i
   , input                                ram_hi_i
   , input                                mode_we_i
  );

  int unsigned failures = 0;
  logic        mode_written_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mode_written_r <= 1'b0;
    end else if (mode_we_i) begin
      mode_written_r <= 1'b1;
    end
  end

  payload_held: assert property (@(posedge clk_i) disable iff (reset_i)
    cfg_v_i && !cfg_ready_i |=> cfg_v_i && $stable(cfg_req_i))
    else begin
      $error("config payload or valid changed while ready was low");
      failures++;
    end

  busy_after_hi: assert property (@(posedge clk_i) disable iff (reset_i)
    ram_w_v_i && ram_hi_i |=> !cfg_ready_i)
    else begin
      $error("ready stayed high after a high-half transfer");
      failures++;
    end

  mode_once: assert property (@(posedge clk_i) disable iff (reset_i)
    mode_written_r |-> !mode_we_i)
    else begin
      $error("mode register written a second time");
      failures++;
    end

endmodule

bind cce_cfg_decode cce_boot_assertions decode_asserts
  (.clk_i, .reset_i, .cfg_req_i, .cfg_v_i, .cfg_ready_i(cfg_ready_o)
   , .ram_w_v_i(ram_w_v_o), .ram_hi_i(ram_hi_o), .mode_we_i(mode_we));

// ==== sim/cce_boot_checker.sv ====
module cce_boot_checker
  #(parameter inst_ram_els_p = cce_cfg_pkg::inst_ram_els_c
    , localparam addr_width_lp = $clog2(inst_ram_els_p)
  )
  (input                                                    clk_i
   , input                                                  reset_i
   , input cce_cfg_pkg::ucode_inst_s [inst_ram_els_p-1:0]   rom_i
   , input [addr_width_lp-1:0]                              boot_rom_addr_i
   , input                                                  freeze_i
   , input                                                  result_v_i
   , input cce_cfg_pkg::ucode_result_s                      result_i
   , input                                                  done_i
   , input                                                  end_i
   , output logic                                           reported_o
   , output int                                             tests_passed_o
   , output int                                             tests_failed_o
  );

  import cce_cfg_pkg::*;

  int          exp_pc_q[$];
  logic [15:0] exp_val_q[$];
  int          cur_idx;
  int          run_len;
  int          result_count;
  bit          order_started;
  bit          order_done;
  bit          freeze_fell;
  bit          done_seen;
  int          err_freeze;
  int          err_order;
  int          err_results;
  int          err_halt;
  int          err_quiet;

  // sequential run of the ROM program, accumulator starts at zero
  task automatic build_model();
    logic [15:0] acc;
    bit          stop;
    acc  = '0;
    stop = 1'b0;
    for (int i = 0; i < inst_ram_els_p; i++) begin
      if (!stop) begin
        case (rom_i[i].op)
          op_addi: acc = acc + rom_i[i].imm;
          op_xori: acc = acc ^ rom_i[i].imm;
          op_shl:  acc = acc << rom_i[i].imm[3:0];
          op_emit: begin
            exp_pc_q.push_back(i);
            exp_val_q.push_back(acc);
          end
          op_halt: stop = 1'b1;
          default: ;
        endcase
      end
    end
  endtask

  task automatic check_order();
    if (!order_started) begin
      order_started = 1'b1;
      cur_idx       = boot_rom_addr_i;
      run_len       = 1;
      if (boot_rom_addr_i != 0) begin
        $display("Mismatch load_order: expected index 0, actual %0d", boot_rom_addr_i);
        err_order++;
      end
    end else if (boot_rom_addr_i == cur_idx) begin
      run_len++;
    end else begin
      if (run_len < 2) begin
        $display("load_order: index %0d was presented for only one cycle", cur_idx);
        err_order++;
      end
      if (cur_idx == inst_ram_els_p-1) begin
        order_done = 1'b1; // loader has moved on to the mode register
      end else if (boot_rom_addr_i != cur_idx+1) begin
        $display("Mismatch load_order: expected index %0d, actual %0d",
                 cur_idx+1, boot_rom_addr_i);
        err_order++;
      end
      cur_idx = boot_rom_addr_i;
      run_len = 1;
    end
  endtask

  task automatic check_result();
    if (done_i === 1'b1) begin
      $display("halt: result strobe while done_o is high");
      err_halt++;
    end
    if (result_count >= exp_pc_q.size()) begin
      $display("results: strobe %0d has no counterpart in the model run", result_count);
      err_results++;
    end else if (result_i.pc !== exp_pc_q[result_count]
                 || result_i.value !== exp_val_q[result_count]) begin
      $display("Mismatch results: strobe %0d expected pc %0d value %04h, actual pc %0d value %04h",
               result_count, exp_pc_q[result_count], exp_val_q[result_count],
               result_i.pc, result_i.value);
      err_results++;
    end
    result_count++;
  endtask

  task automatic report_test(input string name, input int errors);
    if (errors == 0) begin
      $display("test %-10s ok", name);
      tests_passed_o++;
    end else begin
      $display("test %-10s failed with %0d error(s)", name, errors);
      tests_failed_o++;
    end
  endtask

  task automatic final_report();
    if (!freeze_fell) begin
      $display("freeze: freeze_o never fell");
      err_freeze++;
    end
    if (!done_seen) begin
      $display("halt: done_o never rose");
      err_halt++;
    end
    if (result_count != exp_pc_q.size()) begin
      $display("Mismatch halt: expected %0d result strobes, actual %0d",
               exp_pc_q.size(), result_count);
      err_halt++;
    end
    report_test("freeze", err_freeze);
    report_test("load_order", err_order);
    report_test("results", err_results);
    report_test("halt", err_halt);
    report_test("quiet", err_quiet);
    reported_o = 1'b1;
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      exp_pc_q.delete();
      exp_val_q.delete();
      cur_idx        = 0;
      run_len        = 0;
      result_count   = 0;
      order_started  = 1'b0;
      order_done     = 1'b0;
      freeze_fell    = 1'b0;
      done_seen      = 1'b0;
      err_freeze     = 0;
      err_order      = 0;
      err_results    = 0;
      err_halt       = 0;
      err_quiet      = 0;
      reported_o     = 1'b0;
      tests_passed_o = 0;
      tests_failed_o = 0;
    end else begin
      if (freeze_i === 1'b1 && (result_v_i === 1'b1 || done_i === 1'b1)) begin
        $display("quiet: result strobe or done_o while freeze_o is high");
        err_quiet++;
      end
      if (freeze_i === 1'b1) begin
        if (freeze_fell) begin
          $display("freeze: freeze_o rose again after the load");
          err_freeze++;
        end else if (!order_done) begin
          check_order();
        end
      end else if (!freeze_fell) begin
        freeze_fell = 1'b1;
        if (!order_done) begin
          $display("freeze: freeze_o fell before every ROM index was presented");
          err_freeze++;
        end
        build_model(); // ROM contents are settled long before this
      end
      if (result_v_i === 1'b1) begin
        check_result();
      end
      if (done_i === 1'b1) begin
        done_seen = 1'b1;
      end else if (done_seen) begin
        $display("halt: done_o fell after it had risen");
        err_halt++;
      end
      if (end_i && !reported_o) begin
        final_report();
      end
    end
  end

endmodule

// ==== sim/cce_boot_tb.sv ====
module cce_boot_tb;

  import cce_cfg_pkg::*;

  localparam int els_lp          = inst_ram_els_c;
  localparam int addr_width_lp   = $clog2(els_lp);
  localparam int freeze_limit_lp = 500;
  localparam int done_limit_lp   = 100;
  localparam int report_limit_lp = 10;
  localparam int drain_cycles_lp = 8;

  logic                     clk;
  logic                     reset;
  logic [addr_width_lp-1:0] boot_rom_addr;
  logic [inst_width_c-1:0]  boot_rom_data;
  logic                     freeze;
  logic                     result_v;
  ucode_result_s            result;
  logic                     done;
  logic                     end_check;
  logic                     reported;
  int                       tests_passed;
  int                       tests_failed;
  ucode_inst_s [els_lp-1:0] rom;
  integer                   seed;
  bit                       ok;
  int                       cycles;

  assign boot_rom_data = rom[boot_rom_addr]; // the ROM answers in the same cycle

  always #2 clk = ~clk;

  cce_boot_top #(.inst_ram_els_p(els_lp)) DUT
    (.clk_i(clk), .reset_i(reset), .boot_rom_addr_o(boot_rom_addr)
     , .boot_rom_data_i(boot_rom_data), .freeze_o(freeze), .result_v_o(result_v)
     , .result_o(result), .done_o(done));

  cce_boot_checker #(.inst_ram_els_p(els_lp)) monitor
    (.clk_i(clk), .reset_i(reset), .rom_i(rom), .boot_rom_addr_i(boot_rom_addr)
     , .freeze_i(freeze), .result_v_i(result_v), .result_i(result), .done_i(done)
     , .end_i(end_check), .reported_o(reported), .tests_passed_o(tests_passed)
     , .tests_failed_o(tests_failed));

  // halt is rare so most programs run deep, the last slot halts half the time
  task automatic fill_rom();
    integer pick;
    for (int i = 0; i < els_lp; i++) begin
      pick         = $random(seed) & 31;
      rom[i].op    = (pick == 0) ? op_halt : ucode_op_e'(3'(pick % 5));
      rom[i].spare = '0;
      rom[i].imm   = 16'($random(seed));
    end
    if (($random(seed) & 1) == 1) begin
      rom[els_lp-1].op = op_halt;
    end
  endtask

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    end_check = 1'b0;
    seed      = 40;
    fill_rom();
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    cycles = 0;
    while (freeze !== 1'b0 && cycles < freeze_limit_lp) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    ok = (freeze === 1'b0);
    if (!ok) begin
      $display("timeout: freeze_o did not fall within %0d cycles", freeze_limit_lp);
    end

    if (ok) begin
      cycles = 0;
      while (done !== 1'b1 && cycles < done_limit_lp) begin
        @(posedge clk);
        #1;
        cycles++;
      end
      ok = (done === 1'b1);
      if (!ok) begin
        $display("timeout: done_o did not rise within %0d cycles", done_limit_lp);
      end
    end

    if (ok) begin
      repeat (drain_cycles_lp) @(posedge clk); // stray strobes after done would show here
      #1;
      end_check = 1'b1;
      cycles    = 0;
      while (reported !== 1'b1 && cycles < report_limit_lp) begin
        @(posedge clk);
        #1;
        cycles++;
      end
      ok = (reported === 1'b1);
      if (!ok) begin
        $display("timeout: the checker gave no final report");
      end
    end

    if (ok) begin
      $display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
               tests_passed, tests_failed, DUT.decode.decode_asserts.failures);
    end
    if (ok && tests_failed == 0 && DUT.decode.decode_asserts.failures == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== all.f ====
verilog/cce_cfg_pkg.sv
verilog/cce_cfg_loader.sv
verilog/cce_cfg_decode.sv
verilog/cce_inst_ram.sv
verilog/cce_ucode_exec.sv
verilog/cce_boot_top.sv
sim/cce_boot_assertions.sv
sim/cce_boot_checker.sv
sim/cce_boot_tb.sv
